//--- bp_pkg.sv
/*
  Shared types for the 2-bit counter branch predictor.
  The table index is pc[9:2]. There are no tags, so PCs that alias share one counter.
*/
`default_nettype none

package bp_pkg;

    localparam int bp_index_bits         = 8;   // 256 entry counter table
    localparam int bp_index_lsb          = 2;   // word aligned pcs, byte offset ignored
    localparam int mispredict_count_bits = 16;  // saturating event counter width

    // classic bimodal counter, msb gives the predicted direction
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,  // also what a cold entry reads as
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } counter_t;

    // one in-flight prediction, captured at lookup and consumed at resolve
    typedef struct packed {
        logic [bp_index_bits-1:0] index;    // table slot to train
        counter_t                 counter;  // counter value seen at lookup
        logic                     hit;      // valid bit seen at lookup
    } pred_rec_t;

    function automatic logic predicts_taken(counter_t c);
        return c[1];  // upper half of the range means taken
    endfunction

    // move one step toward the real outcome, holding at either end
    function automatic counter_t counter_step(counter_t c, logic taken);
        counter_t next;
        next = c;
        if (taken && c != strong_taken)
            next = counter_t'(c + 2'd1);
        else if (!taken && c != strong_not_taken)
            next = counter_t'(c - 2'd1);
        return next;
    endfunction

endpackage

`default_nettype wire

//--- pred_table.sv
/*
  256 entry table of 2-bit counters, indexed directly.
  Only the valid bits are reset. An invalid entry reads as weak_not_taken with rd_hit low.
  The read is combinational, so a read and a write to one index in the same cycle return the old value.
*/
`default_nettype none

module pred_table
    import bp_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bp_index_bits-1:0] rd_index,    // lookup side
    output counter_t                 rd_counter,
    output logic                     rd_hit,
    input  logic                     wr_en,       // training side
    input  logic [bp_index_bits-1:0] wr_index,
    input  counter_t                 wr_counter
);

    localparam int entries = 2 ** bp_index_bits;

    counter_t           counters [entries];  // payload, meaningful only where valid
    logic [entries-1:0] valid;               // one bit per slot, set on first write

    // cold slots look like weak not-taken, as if freshly allocated
    assign rd_hit     = valid[rd_index];
    assign rd_counter = rd_hit ? counters[rd_index] : weak_not_taken;

    // valid bits, cleared as a whole on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;  // slot now holds a trained counter
        end
    end

    // counter storage, plain write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            counters[wr_index] <= wr_counter;
        end
    end

endmodule

`default_nettype wire

//--- predict_stage.sv
/*
  Lookup side. A lookup is taken only while the FIFO is not full.
  push is combinational, so the FIFO stores the record on the same edge that raises pred_valid.
*/
`default_nettype none

module predict_stage
    import bp_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lookup,      // one cycle strobe
    input  logic [31:0]              lookup_pc,
    input  logic                     full,        // from resolve_fifo
    output logic [bp_index_bits-1:0] rd_index,    // to pred_table
    input  counter_t                 rd_counter,
    input  logic                     rd_hit,
    output logic                     pred_valid,  // one cycle pulse
    output logic                     pred_taken,
    output logic                     pred_hit,
    output logic                     push,        // to resolve_fifo
    output pred_rec_t                push_rec
);

    logic accept;  // lookup that will really be predicted

    assign rd_index = lookup_pc[bp_index_lsb +: bp_index_bits];  // pc[9:2]
    assign accept   = lookup & ~full;  // lookups while full are dropped

    // record goes into the FIFO this edge, before any training of the slot
    assign push           = accept;
    assign push_rec.index = rd_index;
    assign push_rec.counter = rd_counter;
    assign push_rec.hit   = rd_hit;

    // registered prediction outputs, one cycle after the lookup
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
            pred_hit   <= 1'b0;
        end else begin
            pred_valid <= accept;
            if (accept) begin
                pred_taken <= predicts_taken(rd_counter);  // counter msb
                pred_hit   <= rd_hit;                      // low on a cold slot
            end
        end
    end

endmodule

`default_nettype wire

//--- resolve_fifo.sv
/*
  In-order buffer of prediction records waiting for their branch to resolve.
  FIFO_DEPTH must be a power of two, at least 2. A push while full or a pop while
  empty is ignored.
*/
`default_nettype none

module resolve_fifo
    import bp_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  pred_rec_t push_rec,
    input  logic      pop,
    output pred_rec_t head_rec,  // oldest record, valid while not empty
    output logic      empty,
    output logic      full
);

    localparam int ptr_bits = $clog2(FIFO_DEPTH);
    localparam logic [ptr_bits:0] depth_count = FIFO_DEPTH[ptr_bits:0];

    pred_rec_t           mem [FIFO_DEPTH];  // record storage, no reset
    logic [ptr_bits-1:0] wr_ptr;            // wraps by itself, depth is a power of two
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0]   count;             // occupancy, 0 to FIFO_DEPTH
    logic                do_push;
    logic                do_pop;

    assign empty    = (count == '0);
    assign full     = (count == depth_count);
    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign head_rec = mem[rd_ptr];

    // pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

endmodule

`default_nettype wire

//--- update_stage.sv
/*
  Resolve side. A resolve trains the counter of the oldest outstanding record.
  The step starts from the counter seen at lookup, not from the current table value.
  A resolve with nothing in flight is dropped. The mispredict count holds at its maximum.
*/
`default_nettype none

module update_stage
    import bp_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             resolve,        // one cycle strobe
    input  logic                             resolve_taken,  // real outcome
    input  logic                             empty,          // from resolve_fifo
    input  pred_rec_t                        head_rec,
    output logic                             pop,
    output logic                             wr_en,          // to pred_table
    output logic [bp_index_bits-1:0]         wr_index,
    output counter_t                         wr_counter,
    output logic                             mispredict,     // one cycle pulse
    output logic [mispredict_count_bits-1:0] mispredict_count
);

    logic accept;  // resolve that has a record to match
    logic wrong;   // outcome disagrees with the prediction that was made

    assign accept = resolve & ~empty;
    assign wrong  = predicts_taken(head_rec.counter) != resolve_taken;

    // pop and train on the same edge
    assign pop        = accept;
    assign wr_en      = accept;
    assign wr_index   = head_rec.index;
    assign wr_counter = counter_step(head_rec.counter, resolve_taken);

    // registered mispredict flag and its running count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispredict       <= 1'b0;
            mispredict_count <= '0;
        end else begin
            mispredict <= accept & wrong;
            if (accept && wrong && mispredict_count != '1) begin
                mispredict_count <= mispredict_count + 1'b1;  // stops at all ones
            end
        end
    end

endmodule

`default_nettype wire

//--- bp_top.sv
/*
  Bimodal branch direction predictor with in-order resolve.
  Prediction follows lookup by one cycle, and lookup_ready drops when FIFO_DEPTH
  branches are in flight. There is no flush, so every accepted lookup needs a resolve.
*/
`default_nettype none

module bp_top
    import bp_pkg::*;
#(
    parameter int FIFO_DEPTH = 4  // in-flight branches, power of two
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             lookup,
    input  logic [31:0]                      lookup_pc,
    input  logic                             resolve,
    input  logic                             resolve_taken,
    output logic                             lookup_ready,
    output logic                             pred_valid,
    output logic                             pred_taken,
    output logic                             pred_hit,
    output logic                             mispredict,
    output logic [mispredict_count_bits-1:0] mispredict_count
);

    logic [bp_index_bits-1:0] rd_index;
    counter_t                 rd_counter;
    logic                     rd_hit;
    logic                     wr_en;
    logic [bp_index_bits-1:0] wr_index;
    counter_t                 wr_counter;
    logic                     push;
    pred_rec_t                push_rec;
    logic                     pop;
    pred_rec_t                head_rec;
    logic                     empty;
    logic                     full;

    assign lookup_ready = ~full;  // room for one more record

    pred_table u_table (
        .clk(clk), .rst(rst),
        .rd_index(rd_index), .rd_counter(rd_counter), .rd_hit(rd_hit),
        .wr_en(wr_en), .wr_index(wr_index), .wr_counter(wr_counter)
    );

    predict_stage u_predict (
        .clk(clk), .rst(rst),
        .lookup(lookup), .lookup_pc(lookup_pc), .full(full),
        .rd_index(rd_index), .rd_counter(rd_counter), .rd_hit(rd_hit),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_hit(pred_hit),
        .push(push), .push_rec(push_rec)
    );

    resolve_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst(rst),
        .push(push), .push_rec(push_rec), .pop(pop),
        .head_rec(head_rec), .empty(empty), .full(full)
    );

    update_stage u_update (
        .clk(clk), .rst(rst),
        .resolve(resolve), .resolve_taken(resolve_taken),
        .empty(empty), .head_rec(head_rec), .pop(pop),
        .wr_en(wr_en), .wr_index(wr_index), .wr_counter(wr_counter),
        .mispredict(mispredict), .mispredict_count(mispredict_count)
    );

endmodule

`default_nettype wire

//--- tb_bp_top.sv
/*
  Table-driven testbench for bp_top with FIFO_DEPTH 4.
  Expected values come from a behavioral model run over the whole table before it is applied.
*/
`default_nettype none

module tb_bp_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int fifo_depth = 4;
    localparam int max_rows   = 160;

    // one stimulus row, op bit 0 is lookup and op bit 1 is resolve
    typedef struct packed {
        logic [2:0]  test;
        logic [1:0]  op;
        logic [31:0] pc;
        logic        outcome;
        logic        exp_ready;  // lookup_ready while the row is driven
        logic        exp_pv;     // pred_valid after the edge
        logic        exp_taken;
        logic        exp_hit;
        logic        exp_mis;
        logic [15:0] exp_count;
    } row_t;

    logic        clk;
    logic        rst;
    logic        lookup;
    logic [31:0] lookup_pc;
    logic        resolve;
    logic        resolve_taken;
    logic        lookup_ready;
    logic        pred_valid;
    logic        pred_taken;
    logic        pred_hit;
    logic        mispredict;
    logic [15:0] mispredict_count;

    row_t   rows [max_rows];
    int     n_rows;
    int     errors;
    int     checks;
    int     test_errors;
    int     cycles;
    int     cycle_limit;
    integer seed = 32'h97ea288c;
    int     m_ctr [256];    // model counters, 0 strong not-taken .. 3 strong taken
    bit     m_valid [256];
    int     q_idx [$];      // model of in-flight records
    int     q_ctr [$];
    string  test_names [1:6];

    bp_top #(.FIFO_DEPTH(fifo_depth)) UUT (
        .clk(clk), .rst(rst),
        .lookup(lookup), .lookup_pc(lookup_pc),
        .resolve(resolve), .resolve_taken(resolve_taken),
        .lookup_ready(lookup_ready), .pred_valid(pred_valid),
        .pred_taken(pred_taken), .pred_hit(pred_hit),
        .mispredict(mispredict), .mispredict_count(mispredict_count)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    // watchdog, limit set once the table is built
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("simulation hung, no progress after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_row(input int test, input logic [1:0] op, input logic [31:0] pc,
                           input logic outcome);
        rows[n_rows]         = '0;
        rows[n_rows].test    = test[2:0];
        rows[n_rows].op      = op;
        rows[n_rows].pc      = pc;
        rows[n_rows].outcome = outcome;
        n_rows = n_rows + 1;
    endtask

    // saturating 2-bit step toward the outcome
    function automatic int step_toward(input int c, input logic taken);
        if (taken)
            return (c == 3) ? 3 : c + 1;
        else
            return (c == 0) ? 0 : c - 1;
    endfunction

    task automatic run_model();
        int          i;
        int          idx;
        int          c;
        int          pop_idx;
        int          pop_ctr;
        logic        acc_l;
        logic        acc_r;
        logic [15:0] cnt;
        cnt = '0;
        for (i = 0; i < 256; i++)
            m_valid[i] = 1'b0;
        for (i = 0; i < n_rows; i++) begin
            acc_l = rows[i].op[0] && (q_idx.size() < fifo_depth);  // full drops the lookup
            acc_r = rows[i].op[1] && (q_idx.size() != 0);          // orphan resolve dropped
            rows[i].exp_ready = (q_idx.size() < fifo_depth);
            rows[i].exp_pv    = acc_l;
            idx = (rows[i].pc >> 2) & 255;  // pc[9:2]
            c   = 1;
            if (acc_l) begin
                c = m_valid[idx] ? m_ctr[idx] : 1;  // read before any write this cycle
                rows[i].exp_taken = (c >= 2);
                rows[i].exp_hit   = m_valid[idx];
            end
            if (acc_r) begin
                pop_idx = q_idx.pop_front();
                pop_ctr = q_ctr.pop_front();
                rows[i].exp_mis = ((pop_ctr >= 2) != rows[i].outcome);
                if (rows[i].exp_mis && cnt != 16'hffff)
                    cnt = cnt + 1'b1;
                m_ctr[pop_idx]   = step_toward(pop_ctr, rows[i].outcome);
                m_valid[pop_idx] = 1'b1;
            end
            if (acc_l) begin
                q_idx.push_back(idx);
                q_ctr.push_back(c);
            end
            rows[i].exp_count = cnt;
        end
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic build_table();
        int i;
        for (i = 0; i < 3; i++) begin  // cold lookups, each drained
            add_row(1, 2'b01, 32'h0000_1000 + 32'h104 * i, 1'b0);
            add_row(1, 2'b10, 32'h0, 1'b0);
        end
        for (i = 0; i < 4; i++) begin  // train one pc up to strong taken
            add_row(2, 2'b01, 32'h0000_0040, 1'b0);
            add_row(2, 2'b10, 32'h0, 1'b1);
        end
        add_row(2, 2'b01, 32'h0000_0040, 1'b0);
        add_row(2, 2'b10, 32'h0, 1'b0);
        add_row(2, 2'b01, 32'h0000_0040, 1'b0);  // weak taken, still taken
        add_row(2, 2'b10, 32'h0, 1'b1);
        for (i = 0; i < 3; i++) begin
            add_row(3, 2'b01, 32'h0000_0080, 1'b0);
            add_row(3, 2'b10, 32'h0, (i == 0));
        end
        for (i = 0; i < 5; i++)  // fifth lookup meets a full FIFO
            add_row(4, 2'b01, 32'h0000_0300 + 4 * i, 1'b0);
        add_row(4, 2'b10, 32'h0, 1'b1);
        add_row(4, 2'b11, 32'h0000_0310, 1'b0);
        for (i = 0; i < 4; i++)
            add_row(4, 2'b10, 32'h0, i[0]);
        add_row(4, 2'b01, 32'h0000_0300, 1'b0);  // trained taken by the first resolve
        add_row(4, 2'b10, 32'h0, 1'b0);
        add_row(4, 2'b01, 32'h0000_0304, 1'b0);
        add_row(4, 2'b10, 32'h0, 1'b0);
        add_row(5, 2'b01, 32'hABC0_0043, 1'b0);  // aliases 0x40
        add_row(5, 2'b10, 32'h0, 1'b1);
        add_row(5, 2'b01, 32'h0000_0500, 1'b0);
        add_row(5, 2'b11, 32'h0000_1502, 1'b1);  // same index as the update
        add_row(5, 2'b10, 32'h0, 1'b0);
        add_row(5, 2'b01, 32'h0000_0500, 1'b0);
        add_row(5, 2'b10, 32'h0, 1'b1);
        for (i = 0; i < 60; i++)
            add_row(6, $random(seed) & 3,
                    ((($random(seed) & 1) != 0) ? 32'h8000_0000 : 32'h0)
                    + 32'h2000 + (($random(seed) & 7) << 2),
                    $random(seed) & 1);
    endtask

    initial begin
        int i;
        test_names[1] = "cold table";
        test_names[2] = "training";
        test_names[3] = "mispredictions";
        test_names[4] = "back-pressure";
        test_names[5] = "aliasing and same cycle";
        test_names[6] = "random mix";
        rst           = 1'b1;
        lookup        = 1'b0;
        lookup_pc     = '0;
        resolve       = 1'b0;
        resolve_taken = 1'b0;
        n_rows        = 0;
        errors        = 0;
        checks        = 0;
        test_errors   = 0;
        cycles        = 0;
        cycle_limit   = 0;
        build_table();
        run_model();
        cycle_limit = 10 + 4 * n_rows + 50;
        repeat (10) @(posedge clk);
        #5 rst = 1'b0;
        check(mispredict_count, 0, "count after reset");
        for (i = 0; i < n_rows; i++) begin
            check(lookup_ready, rows[i].exp_ready, $sformatf("row %0d lookup_ready", i));
            lookup        = rows[i].op[0];
            resolve       = rows[i].op[1];
            lookup_pc     = rows[i].pc;
            resolve_taken = rows[i].outcome;
            @(posedge clk);
            #5;
            lookup  = 1'b0;
            resolve = 1'b0;
            check(pred_valid, rows[i].exp_pv, $sformatf("row %0d pred_valid", i));
            if (rows[i].exp_pv) begin
                check(pred_taken, rows[i].exp_taken, $sformatf("row %0d pred_taken", i));
                check(pred_hit, rows[i].exp_hit, $sformatf("row %0d pred_hit", i));
            end
            check(mispredict, rows[i].exp_mis, $sformatf("row %0d mispredict", i));
            check(mispredict_count, rows[i].exp_count, $sformatf("row %0d count", i));
            if (i == n_rows - 1 || rows[i + 1].test != rows[i].test) begin
                $display("test %0d %s: %s, %0d errors", rows[i].test,
                         test_names[rows[i].test], test_errors == 0 ? "ok" : "FAIL",
                         test_errors);
                test_errors = 0;
            end
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bp_top.f
bp_pkg.sv
pred_table.sv
predict_stage.sv
resolve_fifo.sv
update_stage.sv
bp_top.sv
tb_bp_top.sv

//--- Bender.yml
package:
  name: bp_top

sources:
  - bp_pkg.sv
  - pred_table.sv
  - predict_stage.sv
  - resolve_fifo.sv
  - update_stage.sv
  - bp_top.sv
  - target: test
    files:
      - tb_bp_top.sv
